// ==== hdl/dispatch_pkg.sv ====
package dispatch_pkg;

    // datapath width
    localparam int xlen = 32;

    // architectural register file
    localparam int reg_num      = 32;
    localparam int reg_addr_len = 5;

    // number of reservation stations, one per functional unit
    localparam int fu_count = 4;

    // functional unit select
    // the value doubles as the bit index into rs_load and rs_full
    typedef enum logic [1:0] {
        fu_alu  = 2'd0,
        fu_mult = 2'd1,
        fu_btu  = 2'd2,
        fu_lsu  = 2'd3
    } fu_t;

    // dispatcher FSM
    // idle      waiting for req from the decoder
    // issue     instruction latched, waiting for station and ROB space
    // hold_ack  ack high until the decoder drops req
    typedef enum logic [1:0] {
        idle     = 2'd0,
        issue    = 2'd1,
        hold_ack = 2'd2
    } disp_state_t;

endpackage

// ==== hdl/dispatch_top.sv ====
`timescale 1ns/1ps

module dispatch_top #(
    parameter int rob_size    = 8,
    parameter int rob_tag_len = $clog2(rob_size)
) (
    input  logic                                  clk,
    input  logic                                  reset,

    // decoder
    input  logic                                  req,
    input  dispatch_pkg::fu_t                     fu,
    input  logic [dispatch_pkg::reg_addr_len-1:0] dest_reg,
    input  logic [dispatch_pkg::reg_addr_len-1:0] src1_reg,
    input  logic [dispatch_pkg::reg_addr_len-1:0] src2_reg,
    input  logic [dispatch_pkg::xlen-1:0]         imm,
    input  logic                                  imm_valid,
    input  logic [dispatch_pkg::xlen-1:0]         pc,
    input  logic                                  pc_valid,
    output logic                                  ack,

    // reservation stations
    input  logic [dispatch_pkg::fu_count-1:0]     rs_full,
    output logic [dispatch_pkg::fu_count-1:0]     rs_load,
    output dispatch_pkg::fu_t                     rs_fu,
    output logic [rob_tag_len-1:0]                rs_tag_dest,
    output logic                                  rs_ready_src1,
    output logic [rob_tag_len-1:0]                rs_tag_src1,
    output logic [dispatch_pkg::xlen-1:0]         rs_value_src1,
    output logic                                  rs_ready_src2,
    output logic [rob_tag_len-1:0]                rs_tag_src2,
    output logic [dispatch_pkg::xlen-1:0]         rs_value_src2,
    output logic [dispatch_pkg::xlen-1:0]         rs_imm,
    output logic [dispatch_pkg::xlen-1:0]         rs_pc,

    // common data bus
    input  logic                                  cdb_valid,
    input  logic [rob_tag_len-1:0]                cdb_tag,
    input  logic [dispatch_pkg::xlen-1:0]         cdb_value,

    // commit
    output logic                                  commit_valid,
    output logic [dispatch_pkg::reg_addr_len-1:0] commit_reg,
    output logic [dispatch_pkg::xlen-1:0]         commit_value
);
    import dispatch_pkg::*;

    logic [reg_addr_len-1:0]       src1_addr;
    logic [reg_addr_len-1:0]       src2_addr;
    logic                          src1_busy;
    logic [rob_tag_len-1:0]        src1_tag;
    logic                          src2_busy;
    logic [rob_tag_len-1:0]        src2_tag;
    logic [xlen-1:0]               rf_data1;
    logic [xlen-1:0]               rf_data2;
    logic                          rob_full;
    logic [rob_tag_len-1:0]        tail_tag;
    logic [rob_size-1:0]           rob_done;
    logic [rob_size-1:0][xlen-1:0] rob_value;
    logic                          alloc;
    logic [reg_addr_len-1:0]       alloc_reg;
    logic [rob_tag_len-1:0]        commit_tag;

    dispatcher #(
        .rob_size    (rob_size),
        .rob_tag_len (rob_tag_len)
    ) dispatcher_i (.*);

    map_table #(
        .rob_size    (rob_size),
        .rob_tag_len (rob_tag_len)
    ) map_table_i (
        .clk          (clk),
        .reset        (reset),
        .src1_reg     (src1_addr),
        .src2_reg     (src2_addr),
        .src1_busy    (src1_busy),
        .src1_tag     (src1_tag),
        .src2_busy    (src2_busy),
        .src2_tag     (src2_tag),
        .alloc        (alloc),
        .alloc_reg    (alloc_reg),
        .tail_tag     (tail_tag),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_tag   (commit_tag)
    );

    reorder_buffer #(
        .rob_size    (rob_size),
        .rob_tag_len (rob_tag_len)
    ) reorder_buffer_i (.*);

    register_file register_file_i (
        .clk          (clk),
        .reset        (reset),
        .src1_reg     (src1_addr),
        .src2_reg     (src2_addr),
        .rf_data1     (rf_data1),
        .rf_data2     (rf_data2),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_value (commit_value)
    );

endmodule

// ==== hdl/dispatcher.sv ====
`timescale 1ns/1ps

module dispatcher #(
    parameter int rob_size    = 8,
    parameter int rob_tag_len = 3
) (
    input  logic                                        clk,
    input  logic                                        reset,

    // decoder four-phase req/ack handshake
    input  logic                                        req,
    input  dispatch_pkg::fu_t                           fu,
    input  logic [dispatch_pkg::reg_addr_len-1:0]       dest_reg,
    input  logic [dispatch_pkg::reg_addr_len-1:0]       src1_reg,
    input  logic [dispatch_pkg::reg_addr_len-1:0]       src2_reg,
    input  logic [dispatch_pkg::xlen-1:0]               imm,
    input  logic                                        imm_valid,
    input  logic [dispatch_pkg::xlen-1:0]               pc,
    input  logic                                        pc_valid,
    output logic                                        ack,

    // map table and register file lookups
    output logic [dispatch_pkg::reg_addr_len-1:0]       src1_addr,
    output logic [dispatch_pkg::reg_addr_len-1:0]       src2_addr,
    input  logic                                        src1_busy,
    input  logic [rob_tag_len-1:0]                      src1_tag,
    input  logic                                        src2_busy,
    input  logic [rob_tag_len-1:0]                      src2_tag,
    input  logic [dispatch_pkg::xlen-1:0]               rf_data1,
    input  logic [dispatch_pkg::xlen-1:0]               rf_data2,

    // reorder buffer
    input  logic                                        rob_full,
    input  logic [rob_tag_len-1:0]                      tail_tag,
    input  logic [rob_size-1:0]                         rob_done,
    input  logic [rob_size-1:0][dispatch_pkg::xlen-1:0] rob_value,
    output logic                                        alloc,
    output logic [dispatch_pkg::reg_addr_len-1:0]       alloc_reg,

    // reservation stations
    input  logic [dispatch_pkg::fu_count-1:0]           rs_full,
    output logic [dispatch_pkg::fu_count-1:0]           rs_load,
    output dispatch_pkg::fu_t                           rs_fu,
    output logic [rob_tag_len-1:0]                      rs_tag_dest,
    output logic                                        rs_ready_src1,
    output logic [rob_tag_len-1:0]                      rs_tag_src1,
    output logic [dispatch_pkg::xlen-1:0]               rs_value_src1,
    output logic                                        rs_ready_src2,
    output logic [rob_tag_len-1:0]                      rs_tag_src2,
    output logic [dispatch_pkg::xlen-1:0]               rs_value_src2,
    output logic [dispatch_pkg::xlen-1:0]               rs_imm,
    output logic [dispatch_pkg::xlen-1:0]               rs_pc
);
    import dispatch_pkg::*;

    disp_state_t             state;
    fu_t                     lat_fu;
    logic [reg_addr_len-1:0] lat_dest;
    logic [xlen-1:0]         lat_imm;
    logic                    lat_imm_valid;
    logic [xlen-1:0]         lat_pc;
    logic                    lat_pc_valid;
    logic                    fire;
    logic                    is_btu;
    logic [xlen:0]           src1_op;
    logic [xlen:0]           src2_op;

    // returns {ready, value}
    function automatic logic [xlen:0] pick_operand(
        input logic            use_alt,
        input logic [xlen-1:0] alt,
        input logic            busy,
        input logic [xlen-1:0] rf,
        input logic            done,
        input logic [xlen-1:0] rob_val
    );
        if (use_alt) return {1'b1, alt};
        if (!busy) return {1'b1, rf};
        if (done) return {1'b1, rob_val};
        return '0;
    endfunction

    // station and ROB must both have room
    assign fire = (state == issue) && !rs_full[lat_fu] && !rob_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle:     if (req) state <= issue;
                issue:    if (fire) state <= hold_ack;
                hold_ack: if (!req) state <= idle;
                default:  state <= idle;
            endcase
        end
    end

    // instruction latch
    always_ff @(posedge clk) begin
        if (state == idle && req) begin
            lat_fu        <= fu;
            lat_dest      <= dest_reg;
            src1_addr     <= src1_reg;
            src2_addr     <= src2_reg;
            lat_imm       <= imm;
            lat_imm_valid <= imm_valid;
            lat_pc        <= pc;
            lat_pc_valid  <= pc_valid;
        end
    end

    assign ack       = (state == hold_ack);
    assign alloc     = fire;
    assign alloc_reg = lat_dest;
    assign is_btu    = (lat_fu == fu_btu);

    always_comb begin
        rs_load         = '0;
        rs_load[lat_fu] = fire;
    end

    // sources read the map before this instruction renames its destination
    assign src1_op = pick_operand(lat_pc_valid && !is_btu, lat_pc, src1_busy, rf_data1,
                                  rob_done[src1_tag], rob_value[src1_tag]);
    assign src2_op = pick_operand(lat_imm_valid && !is_btu, lat_imm, src2_busy, rf_data2,
                                  rob_done[src2_tag], rob_value[src2_tag]);

    assign rs_fu         = lat_fu;
    assign rs_tag_dest   = tail_tag;
    assign rs_ready_src1 = src1_op[xlen];
    assign rs_value_src1 = src1_op[xlen-1:0];
    assign rs_tag_src1   = rs_ready_src1 ? '0 : src1_tag;
    assign rs_ready_src2 = src2_op[xlen];
    assign rs_value_src2 = src2_op[xlen-1:0];
    assign rs_tag_src2   = rs_ready_src2 ? '0 : src2_tag;

    // branch unit needs imm and pc for target calculation
    assign rs_imm = is_btu ? lat_imm : '0;
    assign rs_pc  = is_btu ? lat_pc : '0;

endmodule

// ==== hdl/map_table.sv ====
`timescale 1ns/1ps

module map_table #(
    parameter int rob_size    = 8,
    parameter int rob_tag_len = 3
) (
    input  logic                                  clk,
    input  logic                                  reset,

    // source lookups
    input  logic [dispatch_pkg::reg_addr_len-1:0] src1_reg,
    input  logic [dispatch_pkg::reg_addr_len-1:0] src2_reg,
    output logic                                  src1_busy,
    output logic [rob_tag_len-1:0]                src1_tag,
    output logic                                  src2_busy,
    output logic [rob_tag_len-1:0]                src2_tag,

    // rename on dispatch
    input  logic                                  alloc,
    input  logic [dispatch_pkg::reg_addr_len-1:0] alloc_reg,
    input  logic [rob_tag_len-1:0]                tail_tag,

    // release on commit
    input  logic                                  commit_valid,
    input  logic [dispatch_pkg::reg_addr_len-1:0] commit_reg,
    input  logic [rob_tag_len-1:0]                commit_tag
);
    import dispatch_pkg::*;

    logic [reg_num-1:0]     busy;
    logic [rob_tag_len-1:0] tag [reg_num];
    logic                   commit_hit;

    // a newer writer may have renamed the register since this commit was issued
    assign commit_hit = commit_valid && busy[commit_reg] && (tag[commit_reg] == commit_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (commit_hit) begin
                busy[commit_reg] <= 1'b0;
            end
            // allocation after the clear so it wins on the same register
            if (alloc && alloc_reg != '0) begin
                busy[alloc_reg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc && alloc_reg != '0) begin
            tag[alloc_reg] <= tail_tag;
        end
    end

    assign src1_busy = busy[src1_reg];
    assign src1_tag  = tag[src1_reg];
    assign src2_busy = busy[src2_reg];
    assign src2_tag  = tag[src2_reg];

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                                  clk,
    input  logic                                  reset,

    // read ports
    input  logic [dispatch_pkg::reg_addr_len-1:0] src1_reg,
    input  logic [dispatch_pkg::reg_addr_len-1:0] src2_reg,
    output logic [dispatch_pkg::xlen-1:0]         rf_data1,
    output logic [dispatch_pkg::xlen-1:0]         rf_data2,

    // commit write port
    input  logic                                  commit_valid,
    input  logic [dispatch_pkg::reg_addr_len-1:0] commit_reg,
    input  logic [dispatch_pkg::xlen-1:0]         commit_value
);
    import dispatch_pkg::*;

    logic [xlen-1:0] regs [reg_num];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid && commit_reg != '0) begin
            regs[commit_reg] <= commit_value;
        end
    end

    // x0 is hardwired
    assign rf_data1 = (src1_reg == '0) ? '0 : regs[src1_reg];
    assign rf_data2 = (src2_reg == '0) ? '0 : regs[src2_reg];

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int rob_size    = 8,
    parameter int rob_tag_len = 3
) (
    input  logic                                        clk,
    input  logic                                        reset,

    // allocation from the dispatcher
    input  logic                                        alloc,
    input  logic [dispatch_pkg::reg_addr_len-1:0]       alloc_reg,
    output logic [rob_tag_len-1:0]                      tail_tag,
    output logic                                        rob_full,

    // completed results for operand forwarding
    output logic [rob_size-1:0]                         rob_done,
    output logic [rob_size-1:0][dispatch_pkg::xlen-1:0] rob_value,

    // common data bus
    input  logic                                        cdb_valid,
    input  logic [rob_tag_len-1:0]                      cdb_tag,
    input  logic [dispatch_pkg::xlen-1:0]               cdb_value,

    // in-order commit
    output logic                                        commit_valid,
    output logic [dispatch_pkg::reg_addr_len-1:0]       commit_reg,
    output logic [rob_tag_len-1:0]                      commit_tag,
    output logic [dispatch_pkg::xlen-1:0]               commit_value
);
    import dispatch_pkg::*;

    logic [rob_tag_len-1:0]  head;
    logic [rob_tag_len-1:0]  tail;
    logic [rob_tag_len:0]    count;
    logic [reg_addr_len-1:0] entry_reg [rob_size];
    logic                    retire;

    function automatic logic [rob_tag_len-1:0] bump(input logic [rob_tag_len-1:0] ptr);
        return (ptr == rob_tag_len'(rob_size - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign tail_tag = tail;
    assign rob_full = (count == (rob_tag_len + 1)'(rob_size));
    assign retire   = (count != '0) && rob_done[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            rob_done     <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            // done is cleared on allocation, not on retire, so the value
            // stays readable during the commit cycle
            if (alloc) begin
                rob_done[tail] <= 1'b0;
                tail           <= bump(tail);
            end
            if (cdb_valid) begin
                rob_done[cdb_tag] <= 1'b1;
            end
            if (retire) begin
                head <= bump(head);
            end
            if (alloc && !retire) begin
                count <= count + 1'b1;
            end else if (!alloc && retire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_reg[tail] <= alloc_reg;
        end
        if (cdb_valid) begin
            rob_value[cdb_tag] <= cdb_value;
        end
        if (retire) begin
            commit_reg   <= entry_reg[head];
            commit_tag   <= head;
            commit_value <= rob_value[head];
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module dispatch_tb -f verilog.f -o sim_dispatch
./obj_dir/sim_dispatch > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
fi
exit 1

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // released on a falling edge, away from the DUT's sampling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== testbench/dispatch_patterns.txt ====
// d/5: kind fu dest src1 src2 imm pc flags(1=imm_valid 2=pc_valid) bp tag_dest
//      rt1 val1 rt2 val2 rs_imm rs_pc   (rt = 1x ready, 0t waiting on tag t; 5 = expect stall)
// b: kind tag value, c: kind reg value, rest zero; a zero kind ends the run
d 0 1 2 3 0 0 0 0 0 10 0 10 0 0 0
d 1 4 1 5 0 0 0 0 1 00 0 10 0 0 0
b 0 11 0 0 0 0 0 0 0 0 0 0 0 0 0
d 0 6 1 4 0 0 0 0 2 10 11 01 0 0 0
c 1 11 0 0 0 0 0 0 0 0 0 0 0 0 0
d 3 7 1 0 40 0 1 1 3 10 11 10 40 0 0
d 0 8 5 0 0 1000 2 0 4 10 1000 10 0 0 0
d 2 0 6 1 20 2000 3 1 5 02 0 10 11 20 2000
b 1 22 0 0 0 0 0 0 0 0 0 0 0 0 0
c 4 22 0 0 0 0 0 0 0 0 0 0 0 0 0
b 2 33 0 0 0 0 0 0 0 0 0 0 0 0 0
c 6 33 0 0 0 0 0 0 0 0 0 0 0 0 0
d 0 1 4 3 0 0 0 0 6 10 22 10 0 0 0
d 0 9 1 6 0 0 0 0 7 06 0 10 33 0 0
d 1 a 0 0 0 0 0 0 0 10 0 10 0 0 0
d 3 b 9 2 0 0 0 0 1 07 0 10 0 0 0
d 0 c 0 0 0 0 0 0 2 10 0 10 0 0 0
5 0 d 7 0 0 0 0 0 0 0 0 0 0 0 0
b 3 44 0 0 0 0 0 0 0 0 0 0 0 0 0
d 0 d 7 0 0 0 0 0 3 10 44 10 0 0 0
c 7 44 0 0 0 0 0 0 0 0 0 0 0 0 0
b 4 55 0 0 0 0 0 0 0 0 0 0 0 0 0
c 8 55 0 0 0 0 0 0 0 0 0 0 0 0 0
b 5 66 0 0 0 0 0 0 0 0 0 0 0 0 0
c 0 66 0 0 0 0 0 0 0 0 0 0 0 0 0
b 6 77 0 0 0 0 0 0 0 0 0 0 0 0 0
c 1 77 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== testbench/dispatch_tb.sv ====
`timescale 1ns/1ps

module dispatch_tb;
    import dispatch_pkg::*;

    localparam int row_len  = 16;
    localparam int max_rows = 64;
    localparam int wait_max = 200;

    logic clk, reset, req, imm_valid, pc_valid, ack;
    fu_t  fu, rs_fu;
    logic [reg_addr_len-1:0] dest_reg, src1_reg, src2_reg, commit_reg;
    logic [xlen-1:0] imm, pc, rs_value_src1, rs_value_src2, rs_imm, rs_pc;
    logic [xlen-1:0] cdb_value, commit_value;
    logic [fu_count-1:0] rs_full, rs_load;
    logic [2:0] rs_tag_dest, rs_tag_src1, rs_tag_src2, cdb_tag;
    logic rs_ready_src1, rs_ready_src2, cdb_valid, commit_valid;

    logic [31:0]             pat [row_len*max_rows];
    logic [31:0]             rnd_state;
    int                      step;
    logic [reg_addr_len-1:0] commit_regs [$];
    logic [xlen-1:0]         commit_values [$];

    clock_gen clock_gen_i (.clk(clk), .reset(reset));

    dispatch_top dut_i (.*);

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t: step %0d %s, got %h, expected %h",
                     $time, step, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("Step %0d: %s", step, what);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    // pattern row starts with kind fu dest src1 src2 imm pc flags
    task automatic drive_fields(input int r);
        fu        = fu_t'(pat[r+1][1:0]);
        dest_reg  = pat[r+2][4:0];
        src1_reg  = pat[r+3][4:0];
        src2_reg  = pat[r+4][4:0];
        imm       = pat[r+5];
        pc        = pat[r+6];
        imm_valid = pat[r+7][0];
        pc_valid  = pat[r+7][1];
        req       = 1'b1;
    endtask

    task automatic expect_stall(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value(32'(rs_load), 0, "rs_load while stalled");
            check_value(32'(ack), 0, "ack while stalled");
        end
    endtask

    task automatic run_dispatch(input int r);
        int n;
        int unit;
        unit = int'(pat[r+1][1:0]);
        drive_fields(r);
        if (pat[r+8] != 0) begin
            rnd_state = next_random(rnd_state);
            rs_full[unit] = 1'b1;
            expect_stall(2 + int'(rnd_state % 6));
            rs_full[unit] = 1'b0;
            // rs_load follows rs_full within the same half cycle
            #1;
        end
        n = 0;
        while (rs_load == '0) begin
            if (n == wait_max) report_failure("timeout, rs_load never rose");
            @(negedge clk);
            n++;
        end
        check_value(32'(rs_load), 32'(1 << unit), "rs_load bit");
        check_value(32'(rs_fu), pat[r+1], "rs_fu");
        check_value(32'(rs_tag_dest), pat[r+9], "rs_tag_dest");
        check_value(32'(rs_ready_src1), 32'(pat[r+10][4]), "rs_ready_src1");
        check_value(32'(rs_tag_src1), 32'(pat[r+10][2:0]), "rs_tag_src1");
        check_value(rs_value_src1, pat[r+11], "rs_value_src1");
        check_value(32'(rs_ready_src2), 32'(pat[r+12][4]), "rs_ready_src2");
        check_value(32'(rs_tag_src2), 32'(pat[r+12][2:0]), "rs_tag_src2");
        check_value(rs_value_src2, pat[r+13], "rs_value_src2");
        check_value(rs_imm, pat[r+14], "rs_imm");
        check_value(rs_pc, pat[r+15], "rs_pc");
        @(negedge clk);
        check_value(32'(rs_load), 0, "rs_load after the load pulse");
        check_value(32'(ack), 1, "ack after the station load");
        req = 1'b0;
        n = 0;
        while (ack) begin
            if (n == wait_max) report_failure("timeout, ack never dropped after req fell");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic run_bus(input int r);
        cdb_valid = 1'b1;
        cdb_tag   = pat[r+1][2:0];
        cdb_value = pat[r+2];
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    task automatic expect_commit(input int r);
        int n;
        n = 0;
        while (commit_regs.size() == 0) begin
            if (n == wait_max) report_failure("timeout, commit_valid never rose");
            @(negedge clk);
            n++;
        end
        check_value(32'(commit_regs.pop_front()), pat[r+1], "commit_reg");
        check_value(commit_values.pop_front(), pat[r+2], "commit_value");
    endtask

    // commits can land while another step is running
    always @(negedge clk) begin
        if (!reset && commit_valid) begin
            commit_regs.push_back(commit_reg);
            commit_values.push_back(commit_value);
        end
    end

    initial begin
        int r;
        int n;
        req       = 1'b0;
        fu        = fu_alu;
        dest_reg  = '0;
        src1_reg  = '0;
        src2_reg  = '0;
        imm       = '0;
        imm_valid = 1'b0;
        pc        = '0;
        pc_valid  = 1'b0;
        rs_full   = '0;
        cdb_valid = 1'b0;
        cdb_tag   = '0;
        cdb_value = '0;
        rnd_state = 32'h8917;
        step      = 0;
        for (int i = 0; i < row_len*max_rows; i++) begin
            pat[i] = '0;
        end
        $readmemh("testbench/dispatch_patterns.txt", pat);
        if (pat[0] == '0) report_failure("patterns file is missing or empty");
        n = 0;
        while (reset !== 1'b0) begin
            if (n == wait_max) report_failure("timeout, reset was never released");
            @(negedge clk);
            n++;
        end
        r = 0;
        while (step < max_rows && pat[r] != '0) begin
            case (pat[r])
                32'hd: run_dispatch(r);
                32'h5: begin
                    drive_fields(r);
                    expect_stall(10);
                end
                32'hb: run_bus(r);
                32'hc: expect_commit(r);
                default: report_failure("unknown step kind in patterns file");
            endcase
            step++;
            r = r + row_len;
        end
        if (commit_regs.size() != 0) begin
            report_failure("a commit arrived that no pattern line expected");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
hdl/dispatch_pkg.sv
hdl/register_file.sv
hdl/map_table.sv
hdl/reorder_buffer.sv
hdl/dispatcher.sv
hdl/dispatch_top.sv
testbench/clock_gen.sv
testbench/dispatch_tb.sv
